// ==== common/wallace_settings.svh ====
`ifndef WALLACE_SETTINGS_SVH
`define WALLACE_SETTINGS_SVH

// operand width in bits
`define WALLACE_OP_W 16

// full product width, twice the operand
`define WALLACE_PROD_W 32

// bits per lookahead group in the final adder
`define WALLACE_CLA_GROUP 4

`endif

// ==== common/wallace_pkg.sv ====
`include "wallace_settings.svh"

package wallace_pkg;

  typedef logic signed [`WALLACE_OP_W-1:0] operand_t;
  typedef logic [`WALLACE_OP_W-1:0] magnitude_t;
  typedef logic signed [`WALLACE_PROD_W-1:0] product_t;

  // row i is the multiplicand magnitude gated by multiplier bit i
  typedef logic [`WALLACE_OP_W-1:0][`WALLACE_OP_W-1:0] pp_matrix_t;

  typedef struct packed {
    logic     valid;
    operand_t multiplier;
    operand_t multiplicand;
  } mult_req_t;

  typedef struct packed {
    logic       valid;
    logic       negate;
    pp_matrix_t matrix;
  } pp_stage_t;

  typedef struct packed {
    logic                       valid;
    logic                       negate;
    logic [`WALLACE_PROD_W-1:0] sum_row;
    logic [`WALLACE_PROD_W-1:0] carry_row;
  } csa_stage_t;

  typedef struct packed {
    logic     valid;
    product_t product;
  } mult_rsp_t;

endpackage

// ==== wallace/pp_gen.sv ====
`timescale 1ns/1ns
`include "wallace_settings.svh"

module pp_gen
  import wallace_pkg::*;
(
  input  mult_req_t req,
  output pp_stage_t pp
);

  localparam int N = `WALLACE_OP_W;

  magnitude_t mplier_mag;
  magnitude_t mcand_mag;
  logic       mplier_neg;
  logic       mcand_neg;

  // two's complement when the sign bit is set
  function automatic magnitude_t magnitude(operand_t op);
    magnitude_t mag;
    if (op[N-1]) begin
      mag = magnitude_t'(~op) + magnitude_t'(1);
    end else begin
      mag = magnitude_t'(op);
    end
    return mag;
  endfunction

  assign mplier_neg = req.multiplier[N-1];
  assign mcand_neg  = req.multiplicand[N-1];
  assign mplier_mag = magnitude(req.multiplier);
  assign mcand_mag  = magnitude(req.multiplicand);

  always_comb begin
    pp.valid  = req.valid;
    pp.negate = mplier_neg ^ mcand_neg;
    for (int i = 0; i < N; i++) begin
      pp.matrix[i] = mcand_mag & {N{mplier_mag[i]}};
    end
  end

endmodule

// ==== wallace/csa_reduce.sv ====
`timescale 1ns/1ns
`include "wallace_settings.svh"

module csa_reduce
  import wallace_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  pp_stage_t  pp,
  output csa_stage_t csa
);

  localparam int N = `WALLACE_OP_W;
  localparam int W = `WALLACE_PROD_W;

  // bit count of one column after a given number of layers
  function automatic int col_height(int lay, int col);
    int h [W];
    int nxt [W];
    for (int c = 0; c < W; c++) begin
      h[c] = (c < N) ? c + 1 : ((c < 2 * N - 1) ? 2 * N - 1 - c : 0);
    end
    for (int l = 0; l < lay; l++) begin
      for (int c = 0; c < W; c++) begin
        nxt[c] = h[c] / 3 + ((h[c] % 3 != 0) ? 1 : 0);
        if (c > 0) begin
          nxt[c] += h[c - 1] / 3 + ((h[c - 1] % 3 == 2) ? 1 : 0);
        end
      end
      h = nxt;
    end
    return h[col];
  endfunction

  // carries a column sends left: one per full adder, one per half adder
  function automatic int carry_count(int lay, int col);
    int h;
    h = col_height(lay, col);
    return h / 3 + ((h % 3 == 2) ? 1 : 0);
  endfunction

  function automatic int layer_count();
    int n;
    int tallest;
    n = 0;
    tallest = N;
    while (tallest > 2) begin
      n++;
      tallest = 0;
      for (int c = 0; c < W; c++) begin
        if (col_height(n, c) > tallest) begin
          tallest = col_height(n, c);
        end
      end
    end
    return n;
  endfunction

  // six for a 16x16 matrix
  localparam int NUM_LAYERS = layer_count();

  // column bits per layer, unused positions tied low
  logic [N-1:0] col_bits [0:NUM_LAYERS][0:W-1];
  logic [W-1:0] sum_d;
  logic [W-1:0] carry_d;

  for (genvar c = 0; c < W; c++) begin : g_col0
    for (genvar k = 0; k < N; k++) begin : g_bit
      if (k < col_height(0, c)) begin : g_pp
        localparam int ROW = (c < N) ? k : c - N + 1 + k;
        assign col_bits[0][c][k] = pp.matrix[ROW][c - ROW];
      end else begin : g_zero
        assign col_bits[0][c][k] = 1'b0;
      end
    end
  end

  for (genvar l = 0; l < NUM_LAYERS; l++) begin : g_layer
    logic [N-1:0] carries [0:W-1];

    for (genvar c = 0; c < W; c++) begin : g_col
      localparam int H   = col_height(l, c);
      localparam int NFA = H / 3;
      localparam int OWN = NFA + ((H % 3 != 0) ? 1 : 0);
      localparam int NCO = carry_count(l, c);
      localparam int NCI = (c > 0) ? carry_count(l, c - 1) : 0;

      logic [N-1:0] cur;
      logic [N-1:0] nxt;

      assign cur = col_bits[l][c];

      // 3:2 counters over bit triples
      for (genvar f = 0; f < NFA; f++) begin : g_fa
        assign nxt[f] = cur[3*f] ^ cur[3*f+1] ^ cur[3*f+2];
        assign carries[c][f] = (cur[3*f] & cur[3*f+1]) |
                               (cur[3*f+2] & (cur[3*f] ^ cur[3*f+1]));
      end

      // leftover pair gets a half adder, a single bit drops through
      if (H % 3 == 2) begin : g_ha
        assign nxt[NFA] = cur[H-2] ^ cur[H-1];
        assign carries[c][NFA] = cur[H-2] & cur[H-1];
      end else if (H % 3 == 1) begin : g_pass
        assign nxt[NFA] = cur[H-1];
      end

      for (genvar k = 0; k < NCI; k++) begin : g_cin
        assign nxt[OWN+k] = carries[c-1][k];
      end

      if (OWN + NCI < N) begin : g_pad
        assign nxt[N-1:OWN+NCI] = '0;
      end
      if (NCO < N) begin : g_cpad
        assign carries[c][N-1:NCO] = '0;
      end

      assign col_bits[l+1][c] = nxt;
    end
  end

  for (genvar c = 0; c < W; c++) begin : g_out
    assign sum_d[c]   = col_bits[NUM_LAYERS][c][0];
    assign carry_d[c] = col_bits[NUM_LAYERS][c][1];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csa <= '0;
    end else begin
      csa.valid <= pp.valid;
      if (pp.valid) begin
        csa.negate    <= pp.negate;
        csa.sum_row   <= sum_d;
        csa.carry_row <= carry_d;
      end
    end
  end

  // shifted row sum, the magnitude product the tree must reproduce
  function automatic logic [W-1:0] matrix_value(pp_matrix_t m);
    logic [W-1:0] acc;
    acc = '0;
    for (int i = 0; i < N; i++) begin
      acc += W'(m[i]) << i;
    end
    return acc;
  endfunction

  csa_pair_sum: assert property (@(posedge clk) disable iff (!arst_n)
    csa.valid |-> (csa.sum_row + csa.carry_row) == $past(matrix_value(pp.matrix)))
    else $error("carry-save pair does not add up to the magnitude product");

endmodule

// ==== logic/cla_adder.sv ====
`timescale 1ns/1ns
`include "wallace_settings.svh"

module cla_adder (
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] sum
);

  localparam int W  = `WALLACE_PROD_W;
  localparam int G  = `WALLACE_CLA_GROUP;
  localparam int NG = W / G;

  logic [W-1:0]  gen;
  logic [W-1:0]  prop;
  logic [W-1:0]  carry;
  logic [NG-1:0] grp_g;
  logic [NG-1:0] grp_p;
  logic [NG-1:0] grp_cin;

  assign gen  = a & b;
  assign prop = a ^ b;

  for (genvar j = 0; j < NG; j++) begin : g_grp
    // prefix generate and propagate from the group lsb
    logic [G-1:0] pre_g;
    logic [G-1:0] pre_p;

    always_comb begin
      pre_g[0] = gen[j*G];
      pre_p[0] = prop[j*G];
      for (int i = 1; i < G; i++) begin
        pre_g[i] = gen[j*G+i] | (prop[j*G+i] & pre_g[i-1]);
        pre_p[i] = prop[j*G+i] & pre_p[i-1];
      end
    end

    assign grp_g[j] = pre_g[G-1];
    assign grp_p[j] = pre_p[G-1];

    // every carry inside the group looks straight at the group carry-in
    assign carry[j*G] = grp_cin[j];
    for (genvar i = 1; i < G; i++) begin : g_bit
      assign carry[j*G+i] = pre_g[i-1] | (pre_p[i-1] & grp_cin[j]);
    end
  end

  // group carries ripple upward from the lowest group
  always_comb begin
    grp_cin[0] = 1'b0;
    for (int j = 1; j < NG; j++) begin
      grp_cin[j] = grp_g[j-1] | (grp_p[j-1] & grp_cin[j-1]);
    end
  end

  assign sum = prop ^ carry;

  always_comb begin
    if (!$isunknown({a, b})) begin
      cla_sum_check: assert #0 (sum == a + b)
        else $error("lookahead sum differs from a + b");
    end
  end

endmodule

// ==== logic/product_finish.sv ====
`timescale 1ns/1ns
`include "wallace_settings.svh"

module product_finish
  import wallace_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  csa_stage_t csa,
  output mult_rsp_t  rsp
);

  localparam int W = `WALLACE_PROD_W;

  logic [W-1:0] mag_sum;
  product_t     product_d;

  cla_adder cla_adder_i (
    .a   (csa.sum_row),
    .b   (csa.carry_row),
    .sum (mag_sum)
  );

  // restore the sign when operand signs differ
  always_comb begin
    if (csa.negate) begin
      product_d = product_t'(~mag_sum + W'(1));
    end else begin
      product_d = product_t'(mag_sum);
    end
  end

  // product holds through gaps in valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp <= '0;
    end else begin
      rsp.valid <= csa.valid;
      if (csa.valid) begin
        rsp.product <= product_d;
      end
    end
  end

  // needs the carry-save stage to come out of reset empty as well
  no_valid_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |=> !rsp.valid)
    else $error("response valid in the first cycle after reset");

endmodule

// ==== wallace/wallace_mult.sv ====
`timescale 1ns/1ns

module wallace_mult
  import wallace_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  mult_req_t req,
  output mult_rsp_t rsp
);

  pp_stage_t  pp;
  csa_stage_t csa;

  // signs, magnitudes and the AND matrix, no register
  pp_gen pp_gen_i (
    .req (req),
    .pp  (pp)
  );

  // tree down to two rows, registered at the output
  csa_reduce csa_reduce_i (
    .clk    (clk),
    .arst_n (arst_n),
    .pp     (pp),
    .csa    (csa)
  );

  // final add and sign, second register
  product_finish product_finish_i (
    .clk    (clk),
    .arst_n (arst_n),
    .csa    (csa),
    .rsp    (rsp)
  );

endmodule

// ==== testbench/wallace_mult_tb.sv ====
`timescale 1ns/1ns

module wallace_mult_tb
  import wallace_pkg::*;
();

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_RANDOM      = 200;
  // reset, idle, gap and restart sequences around the case and random streams
  localparam int DIRECTED_CYCLES = 50;
  localparam int SLACK_CYCLES    = 20;
  localparam logic [15:0] GAP_PATTERN = 16'b1011_0001_1101_0110;

  logic      clk = 1'b0;
  logic      arst_n;
  mult_req_t req;
  mult_rsp_t rsp;
  product_t  exp_in;

  product_t   exp_queue [$];
  logic [1:0] valid_hist = 2'b00;
  operand_t   case_a [$];
  operand_t   case_b [$];
  product_t   case_p [$];
  logic       cases_ready = 1'b0;
  int         mismatches = 0;
  int         failures = 0;
  int         seed = 81;

  always #(CLK_PERIOD / 2) clk = ~clk;

  wallace_mult wallace_mult_i (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .rsp    (rsp)
  );

  function automatic product_t signed_product(operand_t a, operand_t b);
    return product_t'(a) * product_t'(b);
  endfunction

  task automatic check_product(input product_t got, input product_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: product %0d (%h), expected %0d (%h)",
               $time, got, got, exp, exp);
      mismatches++;
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: rsp.valid is %b, expected %b", $time, got, exp);
      mismatches++;
    end
  endtask

  task automatic load_cases();
    int       fd;
    int       n;
    string    line;
    operand_t a;
    operand_t b;
    product_t p;
    fd = $fopen("testbench/mult_cases.txt", "r");
    if (fd == 0) begin
      $display("case file missing: testbench/mult_cases.txt could not be opened");
      failures++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") begin
          if ($sscanf(line, "%h %h %h", a, b, p) == 3) begin
            case_a.push_back(a);
            case_b.push_back(b);
            case_p.push_back(p);
          end
        end
      end
      $fclose(fd);
      if (case_a.size() == 0) begin
        $display("case file holds no operand pairs");
        failures++;
      end
    end
  endtask

  task automatic drive_pair(input operand_t a, input operand_t b, input product_t p);
    @(negedge clk);
    req.valid        = 1'b1;
    req.multiplier   = a;
    req.multiplicand = b;
    exp_in           = p;
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      req.valid = 1'b0;
    end
  endtask

  task automatic drive_random(input logic valid);
    operand_t a;
    operand_t b;
    a = operand_t'($random(seed));
    b = operand_t'($random(seed));
    if (valid) begin
      drive_pair(a, b, signed_product(a, b));
    end else begin
      drive_idle(1);
    end
  endtask

  // expected pipeline, sampled on the rising edge like the two DUT registers
  always @(posedge clk) begin
    if (!arst_n) begin
      valid_hist <= 2'b00;
      exp_queue.delete();
    end else begin
      valid_hist <= {valid_hist[0], req.valid};
      if (req.valid) begin
        exp_queue.push_back(exp_in);
      end
    end
  end

  always @(negedge clk) begin
    check_valid(rsp.valid, valid_hist[1]);
    if (rsp.valid === 1'b1) begin
      if (exp_queue.size() == 0) begin
        $display("response with empty queue at %0t ns", $time);
        failures++;
      end else begin
        check_product(rsp.product, exp_queue.pop_front());
      end
    end
  end

  initial begin
    arst_n = 1'b0;
    req    = '0;
    exp_in = '0;
    load_cases();
    cases_ready = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    drive_idle(2);
    // case pairs back to back
    foreach (case_a[i]) begin
      drive_pair(case_a[i], case_b[i], case_p[i]);
    end
    drive_idle(3);
    for (int i = 0; i < 16; i++) begin
      drive_random(GAP_PATTERN[i]);
    end
    drive_idle(3);
    // first pair sits in the csa stage, second on the input when reset hits
    drive_random(1'b1);
    drive_random(1'b1);
    arst_n = 1'b0;
    drive_idle(2);
    arst_n = 1'b1;
    drive_idle(2);
    repeat (NUM_RANDOM) begin
      drive_random(1'b1);
    end
    drive_idle(4);
    if (exp_queue.size() != 0) begin
      $display("no response for %0d pairs at the end of the run", exp_queue.size());
      failures++;
    end
    $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (cases_ready);
    limit = case_a.size() + NUM_RANDOM + DIRECTED_CYCLES + SLACK_CYCLES;
    #(limit * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clock cycles", limit);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== testbench/mult_cases.txt ====
# columns: multiplier multiplicand expected_product, all hex
# operands are 16-bit two's complement, product is 32-bit two's complement
0000 0000 00000000
0000 7fff 00000000
0001 0001 00000001
ffff 0001 ffffffff
ffff ffff 00000001
0001 8000 ffff8000
7fff 7fff 3fff0001
8000 8000 40000000
8000 7fff c0008000
7fff ffff ffff8001
8000 ffff 00008000
8000 0001 ffff8000
0002 0003 00000006
fffe 0003 fffffffa
0064 ff9c ffffd8f0
ff9c ff9c 00002710
1234 0010 00012340
00ff 00ff 0000fe01
0100 0100 00010000
4000 0004 00010000
4000 4000 10000000
c000 4000 f0000000
c000 c000 10000000
0003 fff9 ffffffeb
7fff 0002 0000fffe
8000 0000 00000000
aaaa 5555 e38e1c72
1234 5678 06260060

// ==== tb.f ====
+incdir+common
common/wallace_pkg.sv
wallace/pp_gen.sv
wallace/csa_reduce.sv
logic/cla_adder.sv
logic/product_finish.sv
wallace/wallace_mult.sv
testbench/wallace_mult_tb.sv

// ==== Bender.yml ====
package:
  name: wallace_mult

sources:
  - include_dirs:
      - common
    files:
      - common/wallace_pkg.sv
      - wallace/pp_gen.sv
      - wallace/csa_reduce.sv
      - logic/cla_adder.sv
      - logic/product_finish.sv
      - wallace/wallace_mult.sv
      - target: test
        files:
          - testbench/wallace_mult_tb.sv
